//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := scope_ctrl_tb
FILELIST  := sources.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/host_regs.sv
`timescale 1ns/1ps

module host_regs import scope_ctrl_pkg::*; (
  input  logic                                clk_ext,
  input  logic                                rst_ext,
  input  logic                                host_cs,
  input  logic                                host_rnw,
  input  logic [addr_w-1:0]                   host_addr,
  input  logic [data_w-1:0]                   host_wdata,
  output logic [data_w-1:0]                   host_rdata,
  input  logic [dip_w-1:0]                    dip,
  output logic [led_w-1:0]                    leds,
  input  logic [num_timers-1:0][timer_w-1:0]  timer_counts,
  output logic [num_timers-1:0]               timer_start_pulse,
  output logic [num_timers-1:0]               timer_stop_pulse,
  link_cfg_if.regs                            link
);

  logic [word_w-1:0]     word_idx;
  logic                  wr_en;
  logic                  rd_hit;     // counted read
  logic [led_w-1:0]      leds_q;
  logic                  test_q;
  logic [15:0]           link_cfg_q;
  logic [15:0]           link_freq_q;
  logic [31:0]           link_echo_q;
  logic [num_timers-1:0] timer_start_q;
  logic [num_timers-1:0] timer_stop_q;
  logic [2*num_timers:0] edge_src;   // {stop, start, test}
  logic [2*num_timers:0] edge_d;
  logic [2*num_timers:0] edge_pulse;
  logic [sample_w-1:0]   sample_i;
  logic [sample_w-1:0]   sample_q;
  link_msg_u             msg;

  assign word_idx = host_addr[addr_w-1:2];  // byte lanes ignored
  assign wr_en    = host_cs & ~host_rnw;
  assign rd_hit   = host_cs & host_rnw;

  // ======================================================================
  // write decode
  // ======================================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      leds_q        <= '0;
      test_q        <= 1'b0;
      link_cfg_q    <= '0;
      link_freq_q   <= '0;
      link_echo_q   <= '0;
      timer_start_q <= '0;
      timer_stop_q  <= '0;
    end else if (wr_en) begin
      case (word_idx)
        reg_leds:        leds_q        <= host_wdata[led_w-1:0];
        reg_test:        test_q        <= host_wdata[0];
        reg_link_cfg:    link_cfg_q    <= host_wdata[15:0];
        reg_link_freq:   link_freq_q   <= host_wdata[15:0];
        reg_link_echo:   link_echo_q   <= host_wdata;
        reg_timer_start: timer_start_q <= host_wdata[num_timers-1:0];
        reg_timer_stop:  timer_stop_q  <= host_wdata[num_timers-1:0];
        default: ;  // read-only or unmapped, write dropped
      endcase
    end
  end

  assign leds = leds_q;

  // rising edge pulses, one shared detector for test bit and timer bits
  assign edge_src = {timer_stop_q, timer_start_q, test_q};

  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      edge_d     <= '0;
      edge_pulse <= '0;
    end else begin
      edge_d     <= edge_src;
      edge_pulse <= edge_src & ~edge_d;  // one cycle, edge after the write
    end
  end

  assign link.start        = edge_pulse[0];
  assign timer_start_pulse = edge_pulse[num_timers:1];
  assign timer_stop_pulse  = edge_pulse[2*num_timers:num_timers+1];

  // link message through the field view
  always_comb begin
    msg              = '0;  // pad stays zero
    msg.fields.mode    = link_cfg_q[7:0];
    msg.fields.len_log = link_cfg_q[15:8];
    msg.fields.freq    = link_freq_q;
    msg.fields.echo    = link_echo_q;
  end

  assign link.msg = msg;

  // ======================================================================
  // test pattern sample counter
  // ======================================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      sample_i <= sample_i_init;
      sample_q <= sample_q_init;
    end else if (test_q) begin
      // held at start values while test bit set
      sample_i <= sample_i_init;
      sample_q <= sample_q_init;
    end else if (rd_hit) begin
      sample_i <= sample_i + 1'b1;  // bump after the read sees old value
      sample_q <= sample_q + 1'b1;
    end
  end

  // ======================================================================
  // read mux, combinational, ignores cs
  // ======================================================================
  always_comb begin
    host_rdata = read_default;
    case (word_idx)
      reg_id:          host_rdata = firmware_id;
      reg_version:     host_rdata = {firmware_major, firmware_minor};
      reg_dip:         host_rdata = {{(data_w-dip_w){1'b0}}, dip};
      reg_sample:      host_rdata = {sample_q, sample_i};
      reg_leds:        host_rdata = {{(data_w-led_w){1'b0}}, leds_q};
      reg_test:        host_rdata = {{(data_w-1){1'b0}}, test_q};
      reg_link_cfg:    host_rdata = {16'b0, link_cfg_q};
      reg_link_freq:   host_rdata = {16'b0, link_freq_q};
      reg_link_echo:   host_rdata = link_echo_q;
      reg_timer_start: host_rdata = {{(data_w-num_timers){1'b0}}, timer_start_q};
      reg_timer_stop:  host_rdata = {{(data_w-num_timers){1'b0}}, timer_stop_q};
      reg_status:      host_rdata = {{(data_w-1){1'b0}}, link.busy};
      default: begin
        for (int k = 0; k < num_timers; k++) begin
          if (word_idx == reg_timer_base + word_w'(k)) begin
            host_rdata = timer_counts[k];  // timer window
          end
        end
      end
    endcase
  end

endmodule

//--- hw/link_cfg_if.sv
`timescale 1ns/1ps

interface link_cfg_if import scope_ctrl_pkg::*; ();

  link_msg_u msg;    // mode, length, freq, echo
  logic      start;  // one cycle kick
  logic      busy;   // message in flight

  // register side
  modport regs (
    output msg,
    output start,
    input  busy
  );

  // link master side
  modport xmit (
    input  msg,
    input  start,
    output busy
  );

endinterface

//--- hw/link_transmitter.sv
`timescale 1ns/1ps

module link_transmitter import scope_ctrl_pkg::*; (
  input  logic               clk_ext,
  input  logic               rst_ext,
  input  logic               link_ack,
  output logic [chunk_w-1:0] link_bus,
  output logic               link_req,
  link_cfg_if.xmit           link
);

  logic [1:0]             state;
  logic [chunk_idx_w-1:0] chunk_idx;
  logic                   last_chunk;
  link_msg_u              msg_q;      // frozen copy for the whole message

  assign last_chunk = (chunk_idx == chunk_idx_w'(num_chunks - 1));
  assign link.busy  = (state != xmit_idle);  // high from edge after start to final release

  // message latch
  always_ff @(posedge clk_ext) begin
    if (state == xmit_idle && link.start) begin
      msg_q <= link.msg;
    end
  end

  // ======================================================================
  // four phase req/ack, one pass per chunk
  // ======================================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      state     <= xmit_idle;
      chunk_idx <= '0;
      link_bus  <= '0;
      link_req  <= 1'b0;
    end else begin
      case (state)
        xmit_idle: begin
          if (link.start) begin  // start while busy never reaches here
            chunk_idx <= '0;
            link_bus  <= link.msg.chunks[0];  // latch not loaded yet
            link_req  <= 1'b1;
            state     <= xmit_request;
          end
        end
        xmit_request: begin
          if (link_ack) begin
            link_req <= 1'b0;  // phase 3
            state    <= xmit_release;
          end
        end
        xmit_release: begin
          if (!link_ack) begin  // phase 4 seen
            if (last_chunk) begin
              state <= xmit_idle;
            end else begin
              chunk_idx <= chunk_idx + 1'b1;
              link_bus  <= msg_q.chunks[chunk_idx + 1'b1];  // req low, safe to change
              state     <= xmit_next;
            end
          end
        end
        xmit_next: begin
          link_req <= 1'b1;  // bus held one cycle before req
          state    <= xmit_request;
        end
        default: state <= xmit_idle;
      endcase
    end
  end

endmodule

//--- hw/scope_ctrl_pkg.sv
package scope_ctrl_pkg;

  // ======================================================================
  // host bus widths
  // ======================================================================
  localparam int data_w = 32;          // host data word
  localparam int addr_w = 16;          // host byte address
  localparam int word_w = addr_w - 2;  // word index, byte lanes dropped
  localparam int dip_w  = 8;
  localparam int led_w  = 4;

  // identity words
  localparam logic [data_w-1:0] firmware_id    = 32'h5343_4f50;  // "SCOP" in ascii
  localparam logic [15:0]       firmware_major = 16'h0002;
  localparam logic [15:0]       firmware_minor = 16'h0004;
  localparam logic [data_w-1:0] read_default   = 32'hffff_0bad;  // unmapped index

  // ======================================================================
  // register map, word indices
  // ======================================================================
  localparam logic [word_w-1:0] reg_id          = word_w'(0);   // ro
  localparam logic [word_w-1:0] reg_version     = word_w'(1);   // ro, major:minor
  localparam logic [word_w-1:0] reg_dip         = word_w'(2);   // ro
  localparam logic [word_w-1:0] reg_sample      = word_w'(3);   // ro, q:i
  localparam logic [word_w-1:0] reg_leds        = word_w'(4);
  localparam logic [word_w-1:0] reg_test        = word_w'(5);   // bit 0 only
  localparam logic [word_w-1:0] reg_link_cfg    = word_w'(6);   // [15:8] len log, [7:0] mode
  localparam logic [word_w-1:0] reg_link_freq   = word_w'(7);
  localparam logic [word_w-1:0] reg_link_echo   = word_w'(8);
  localparam logic [word_w-1:0] reg_timer_start = word_w'(9);
  localparam logic [word_w-1:0] reg_timer_stop  = word_w'(10);
  localparam logic [word_w-1:0] reg_status      = word_w'(11);  // bit 0 link busy
  localparam logic [word_w-1:0] reg_timer_base  = word_w'(16);  // one word per timer

  // timers and test pattern
  localparam int num_timers = 4;
  localparam int timer_w    = 32;
  localparam int sample_w   = 16;  // each half of the sample word
  localparam logic [sample_w-1:0] sample_i_init = 16'd0;
  localparam logic [sample_w-1:0] sample_q_init = 16'd32767;

  // ======================================================================
  // link message
  // ======================================================================
  localparam int chunk_w     = 14;
  localparam int num_chunks  = 5;
  localparam int chunk_idx_w = $clog2(num_chunks);

  // transmitter states
  localparam logic [1:0] xmit_idle    = 2'd0;
  localparam logic [1:0] xmit_request = 2'd1;  // req high, waiting for ack
  localparam logic [1:0] xmit_release = 2'd2;  // req low, waiting for ack to drop
  localparam logic [1:0] xmit_next    = 2'd3;  // bus settled, raise req

  // field view written by the regs, chunk view sent by the link master
  typedef union packed {
    struct packed {
      logic [5:0]  pad;
      logic [7:0]  mode;
      logic [7:0]  len_log;  // test length, log2
      logic [15:0] freq;
      logic [31:0] echo;
    } fields;
    logic [num_chunks-1:0][chunk_w-1:0] chunks;  // chunk 0 = lsbs, goes first
  } link_msg_u;

endpackage

//--- hw/scope_ctrl_top.sv
`timescale 1ns/1ps

module scope_ctrl_top import scope_ctrl_pkg::*; (
  input  logic               clk_ext,
  input  logic               rst_ext,
  // host register port
  input  logic               host_cs,
  input  logic               host_rnw,
  input  logic [addr_w-1:0]  host_addr,
  input  logic [data_w-1:0]  host_wdata,
  output logic [data_w-1:0]  host_rdata,
  // board io
  input  logic [dip_w-1:0]   dip,
  output logic [led_w-1:0]   leds,
  // link to the external unit
  output logic [chunk_w-1:0] link_bus,
  output logic               link_req,
  input  logic               link_ack
);

  logic [num_timers-1:0]              timer_start_pulse;
  logic [num_timers-1:0]              timer_stop_pulse;
  logic [num_timers-1:0][timer_w-1:0] timer_counts;

  link_cfg_if link_cfg ();  // regs to link master

  host_regs host_regs_inst (
    .clk_ext           (clk_ext),
    .rst_ext           (rst_ext),
    .host_cs           (host_cs),
    .host_rnw          (host_rnw),
    .host_addr         (host_addr),
    .host_wdata        (host_wdata),
    .host_rdata        (host_rdata),
    .dip               (dip),
    .leds              (leds),
    .timer_counts      (timer_counts),
    .timer_start_pulse (timer_start_pulse),
    .timer_stop_pulse  (timer_stop_pulse),
    .link              (link_cfg.regs)
  );

  timer_bank timer_bank_inst (
    .clk_ext     (clk_ext),
    .rst_ext     (rst_ext),
    .start_pulse (timer_start_pulse),
    .stop_pulse  (timer_stop_pulse),
    .counts      (timer_counts)
  );

  link_transmitter link_transmitter_inst (
    .clk_ext  (clk_ext),
    .rst_ext  (rst_ext),
    .link_ack (link_ack),
    .link_bus (link_bus),
    .link_req (link_req),
    .link     (link_cfg.xmit)
  );

endmodule

//--- hw/timer_bank.sv
`timescale 1ns/1ps

module timer_bank import scope_ctrl_pkg::*; (
  input  logic                               clk_ext,
  input  logic                               rst_ext,
  input  logic [num_timers-1:0]              start_pulse,
  input  logic [num_timers-1:0]              stop_pulse,
  output logic [num_timers-1:0][timer_w-1:0] counts
);

  logic [num_timers-1:0] running;  // one flag per timer

  // ======================================================================
  // cycle timers
  // ======================================================================
  // count after stop = cycles between the start and stop write edges,
  // the stop edge itself still counts
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      running <= '0;
      counts  <= '0;
    end else begin
      for (int k = 0; k < num_timers; k++) begin
        if (start_pulse[k]) begin
          // restart wins over a stop in the same cycle
          counts[k]  <= '0;
          running[k] <= 1'b1;
        end else begin
          if (running[k]) begin
            counts[k] <= counts[k] + 1'b1;
          end
          if (stop_pulse[k]) begin
            running[k] <= 1'b0;  // freeze, no effect if idle
          end
        end
      end
    end
  end

endmodule

//--- sources.f
hw/scope_ctrl_pkg.sv
hw/link_cfg_if.sv
hw/host_regs.sv
hw/timer_bank.sv
hw/link_transmitter.sv
hw/scope_ctrl_top.sv
verification/scope_ctrl_properties.sv
verification/scope_ctrl_tb.sv

//--- verification/scope_ctrl_properties.sv
`timescale 1ns/1ps

module scope_ctrl_properties import scope_ctrl_pkg::*; (
  input logic               clk_ext,
  input logic               rst_ext,
  input logic               link_req,
  input logic               link_ack,
  input logic [chunk_w-1:0] link_bus
);

  // ======================================================================
  // four phase req/ack rules
  // ======================================================================
  bus_stable: assert property (@(posedge clk_ext) disable iff (rst_ext)
    link_req |=> (!link_req || $stable(link_bus)))
    else $error("link_bus moved while link_req high");

  no_rise_on_ack: assert property (@(posedge clk_ext) disable iff (rst_ext)
    $rose(link_req) |-> !link_ack)
    else $error("link_req rose with link_ack still high");

  fall_after_ack: assert property (@(posedge clk_ext) disable iff (rst_ext)
    $fell(link_req) |-> $past(link_ack))
    else $error("link_req dropped before link_ack");

  // req parked low coming out of reset
  low_after_reset: assert property (@(posedge clk_ext)
    $past(rst_ext) |-> !link_req)
    else $error("link_req high after reset");

endmodule

bind link_transmitter scope_ctrl_properties props_inst (
  .clk_ext  (clk_ext),
  .rst_ext  (rst_ext),
  .link_req (link_req),
  .link_ack (link_ack),
  .link_bus (link_bus)
);

//--- verification/scope_ctrl_tb.sv
`timescale 1ns/1ps

module scope_ctrl_tb import scope_ctrl_pkg::*; ();

  localparam int op_wr = 0, op_rd = 1, op_idle = 2, op_leds = 3, op_wait = 4, op_msgs = 5;

  typedef struct {
    int                op;
    logic [word_w-1:0] idx;    // word index
    logic [31:0]       wdata;  // data, idle cycles or message count
    logic [31:0]       exp;
    int                test;
  } step_t;

  logic clk_ext, rst_ext, host_cs, host_rnw, link_ack, link_req;
  logic [addr_w-1:0]  host_addr;
  logic [data_w-1:0]  host_wdata, host_rdata;
  logic [dip_w-1:0]   dip;
  logic [led_w-1:0]   leds;
  logic [chunk_w-1:0] link_bus;

  step_t     steps[$];
  string     test_names[7] = '{"", "identity", "rw regs", "sample counter", "link message",
                               "link back-pressure", "timers"};
  int        errors = 0, checks = 0, cycles = 0, cycle_limit = 32'h7fff_ffff;
  int        msgs_rx = 0, rx_idx = 0;
  logic [31:0] lfsr_state = 32'h12f1_e7de;
  link_msg_u rx_msg, last_msg, exp_msg;  // exp_msg tracks the host writes

  scope_ctrl_top scope_ctrl_top_inst (.*);

  initial begin
    clk_ext = 1'b0;
    forever #2 clk_ext = ~clk_ext;  // 4 ns
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function int take_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic add(input int op, input logic [word_w-1:0] idx, input logic [31:0] wd,
                     input logic [31:0] ex, input int test);
    step_t s;
    s.op = op;
    s.idx = idx;
    s.wdata = wd;
    s.exp = ex;
    s.test = test;
    steps.push_back(s);
  endtask

  // link slave model with random ack delays of 0..7 cycles
  initial begin : link_slave
    logic [chunk_w-1:0] chunk;
    link_ack = 1'b0;  // idle until the first req
    forever begin
      @(posedge clk_ext);
      if (!rst_ext && link_req) begin
        repeat (take_bits(3)) @(posedge clk_ext);
        chunk = link_bus;
        link_ack <= 1'b1;
        do @(posedge clk_ext); while (link_req);
        repeat (take_bits(3)) @(posedge clk_ext);
        link_ack <= 1'b0;
        rx_msg.chunks[rx_idx] = chunk;  // chunk 0 arrives first
        rx_idx++;
        if (rx_idx == num_chunks) begin
          rx_idx = 0;
          last_msg = rx_msg;
          msgs_rx++;
        end
      end
    end
  end

  always @(posedge clk_ext) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run stopped: cycle limit of %0d reached, DUT stuck", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ======================================================================
  // stimulus table
  // ======================================================================
  task automatic build_table();
    int gap[num_timers] = '{5, 9, 2, 14};
    add(op_rd, reg_sample, 0, {sample_q_init, sample_i_init}, 3);  // first read after reset
    add(op_rd, reg_sample, 0, {sample_q_init + 16'd1, sample_i_init + 16'd1}, 3);
    add(op_rd, reg_sample, 0, {sample_q_init + 16'd2, sample_i_init + 16'd2}, 3);
    add(op_wr, reg_test, 1, 0, 3);
    add(op_idle, 0, 1, 0, 3);
    add(op_rd, reg_sample, 0, {sample_q_init, sample_i_init}, 3);
    add(op_rd, reg_sample, 0, {sample_q_init, sample_i_init}, 3);
    add(op_wr, reg_test, 0, 0, 3);
    add(op_rd, reg_sample, 0, {sample_q_init, sample_i_init}, 3);
    add(op_rd, reg_sample, 0, {sample_q_init + 16'd1, sample_i_init + 16'd1}, 3);
    add(op_wait, 0, 0, 0, 3);  // test bit rise also sent a zero message
    add(op_rd, reg_id, 0, firmware_id, 1);
    add(op_rd, reg_version, 0, {firmware_major, firmware_minor}, 1);
    add(op_rd, reg_dip, 0, 32'h0000_00a5, 1);
    add(op_rd, word_w'(13), 0, read_default, 1);
    add(op_rd, word_w'(31), 0, read_default, 1);
    add(op_wr, reg_leds, 32'h9, 0, 2);
    add(op_leds, 0, 0, 32'h9, 2);
    add(op_rd, reg_leds, 0, 32'h9, 2);
    add(op_wr, reg_link_cfg, 32'h0000_0b3c, 0, 2);
    add(op_wr, reg_link_freq, 32'h0000_a17e, 0, 2);
    add(op_wr, reg_link_echo, 32'hdead_5eed, 0, 2);
    add(op_rd, reg_link_cfg, 0, 32'h0000_0b3c, 2);
    add(op_rd, reg_link_freq, 0, 32'h0000_a17e, 2);
    add(op_rd, reg_link_echo, 0, 32'hdead_5eed, 2);
    add(op_wr, reg_test, 0, 0, 4);
    add(op_wr, reg_test, 1, 0, 4);
    add(op_idle, 0, 2, 0, 4);
    add(op_rd, reg_status, 0, 1, 4);  // in flight
    add(op_wait, 0, 0, 0, 4);
    add(op_rd, reg_status, 0, 0, 4);
    add(op_msgs, 0, 2, 0, 4);
    add(op_wr, reg_link_echo, 32'h0123_4567, 0, 5);
    add(op_wr, reg_test, 0, 0, 5);
    add(op_wr, reg_test, 1, 0, 5);
    add(op_idle, 0, 2, 0, 5);
    add(op_rd, reg_status, 0, 1, 5);
    add(op_wr, reg_test, 0, 0, 5);
    add(op_wr, reg_test, 1, 0, 5);  // lands while busy so it is dropped
    add(op_wait, 0, 0, 0, 5);
    add(op_idle, 0, 4, 0, 5);  // a queued start would raise busy again here
    add(op_wait, 0, 0, 0, 5);
    add(op_msgs, 0, 3, 0, 5);
    for (int k = 0; k < num_timers; k++) begin
      add(op_wr, reg_timer_start, 32'(1 << k), 0, 6);
      add(op_idle, 0, gap[k], 0, 6);
      add(op_wr, reg_timer_stop, 32'(1 << k), 0, 6);
      add(op_idle, 0, 2, 0, 6);
      add(op_rd, reg_timer_base + word_w'(k), 0, gap[k] + 1, 6);
    end
    for (int k = 0; k < num_timers; k++) begin
      add(op_rd, reg_timer_base + word_w'(k), 0, gap[k] + 1, 6);
    end
  endtask

  initial begin
    step_t s;
    int    test_err;
    host_cs = 1'b0;
    host_rnw = 1'b1;
    host_addr = '0;
    host_wdata = '0;
    dip = 8'ha5;
    rst_ext = 1'b1;
    exp_msg = '0;
    build_table();
    // reset, table time, three messages at 20 cycles worst case per chunk, margin
    cycle_limit = 10 + 200 + 3 * num_chunks * 20;
    foreach (steps[i]) begin
      cycle_limit += (steps[i].op == op_idle) ? int'(steps[i].wdata) : 2;
    end
    repeat (10) @(posedge clk_ext);
    rst_ext <= 1'b0;
    test_err = 0;
    for (int i = 0; i < steps.size(); i++) begin
      s = steps[i];
      @(posedge clk_ext);
      host_cs <= (s.op == op_wr) || (s.op == op_rd) || (s.op == op_wait);
      host_rnw <= (s.op != op_wr);
      host_addr <= (s.op == op_wait) ? {reg_status, 2'b00} : {s.idx, 2'b00};
      host_wdata <= s.wdata;
      case (s.op)
        op_wr: begin
          if (s.idx == reg_link_cfg) begin
            {exp_msg.fields.len_log, exp_msg.fields.mode} = s.wdata[15:0];
          end
          if (s.idx == reg_link_freq) exp_msg.fields.freq = s.wdata[15:0];
          if (s.idx == reg_link_echo) exp_msg.fields.echo = s.wdata;
        end
        op_rd: begin
          @(negedge clk_ext);
          check("host_rdata", host_rdata, s.exp);
        end
        op_idle: repeat (s.wdata - 1) @(posedge clk_ext);
        op_leds: begin
          @(negedge clk_ext);
          check("leds", 32'(leds), s.exp);
        end
        op_wait: begin
          @(negedge clk_ext);
          while (host_rdata[0]) begin  // poll status until busy drops
            @(negedge clk_ext);
          end
        end
        op_msgs: begin
          @(negedge clk_ext);
          check("message count", msgs_rx, s.wdata);
          for (int c = 0; c < num_chunks; c++) begin
            check($sformatf("link_bus chunk %0d", c), 32'(last_msg.chunks[c]),
                  32'(exp_msg.chunks[c]));
          end
        end
        default: ;
      endcase
      if (i == steps.size() - 1 || steps[i + 1].test != s.test) begin
        $display("test %0d %s done, %0d errors", s.test, test_names[s.test], errors - test_err);
        test_err = errors;
      end
    end
    @(posedge clk_ext);
    host_cs <= 1'b0;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
